// ==== dualExecPkg.sv ====
`default_nettype none

package dualExecPkg;

    localparam int DATA_W = 32;
    localparam int REG_W  = 5;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    // one word, two decodings.
    typedef union packed {
        struct packed {
            logic [5:0]       op;
            logic [REG_W-1:0] rs;
            logic [REG_W-1:0] rt;
            logic [REG_W-1:0] rd;
            logic [4:0]       shamt;
            logic [5:0]       funct;
        } rType;
        struct packed {
            logic [5:0]       op;
            logic [REG_W-1:0] rs;
            logic [REG_W-1:0] rt;
            logic [15:0]      imm16;
        } iType;
    } instWord_u;

    typedef struct packed {
        logic [DATA_W-1:0] value;
        logic              write;
        logic [REG_W-1:0]  dest;
        logic              overflow;
    } aluResult_t;

    // second ALU operand, register or extended immediate.
    function automatic logic [DATA_W-1:0] operandB(instWord_u inst, logic [DATA_W-1:0] rtValue);
        logic [15:0] imm;
        imm = inst.iType.imm16;
        case (inst.iType.op)
            OP_SPECIAL:      operandB = rtValue;
            OP_ANDI, OP_ORI: operandB = {16'h0000, imm}; // logical ops zero extend.
            OP_LUI:          operandB = {imm, 16'h0000};
            default:         operandB = {{16{imm[15]}}, imm};
        endcase
    endfunction

    function automatic aluResult_t aluCompute(instWord_u inst, logic [DATA_W-1:0] a,
                                              logic [DATA_W-1:0] b);
        aluResult_t r;
        logic [DATA_W-1:0] sum;
        logic [DATA_W-1:0] diff;
        logic addOvf;
        logic subOvf;
        sum    = a + b;
        diff   = a - b;
        addOvf = (a[DATA_W-1] == b[DATA_W-1]) && (sum[DATA_W-1] != a[DATA_W-1]);
        subOvf = (a[DATA_W-1] != b[DATA_W-1]) && (diff[DATA_W-1] != a[DATA_W-1]);
        r = '0;
        case (inst.rType.op)
            OP_SPECIAL: begin
                r.dest  = inst.rType.rd;
                r.write = 1'b1;
                case (inst.rType.funct)
                    FN_ADD: begin
                        r.value    = sum;
                        r.overflow = addOvf;
                    end
                    FN_ADDU: r.value = sum;
                    FN_SUB: begin
                        r.value    = diff;
                        r.overflow = subOvf;
                    end
                    FN_SUBU: r.value = diff;
                    FN_AND:  r.value = a & b;
                    FN_OR:   r.value = a | b;
                    FN_XOR:  r.value = a ^ b;
                    FN_SLT:  r.value = {{(DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
                    FN_SLL:  r.value = b << inst.rType.shamt;
                    FN_SRL:  r.value = b >> inst.rType.shamt;
                    default: r.write = 1'b0; // unknown funct is a no-op.
                endcase
            end
            OP_ADDI: begin
                r.dest     = inst.iType.rt;
                r.write    = 1'b1;
                r.value    = sum;
                r.overflow = addOvf;
            end
            OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI: begin
                r.dest  = inst.iType.rt;
                r.write = 1'b1;
                case (inst.iType.op)
                    OP_ANDI: r.value = a & b;
                    OP_ORI:  r.value = a | b;
                    OP_LUI:  r.value = b;
                    default: r.value = sum;
                endcase
            end
            default: r.write = 1'b0; // branches and the rest write nothing.
        endcase
        if (r.dest == '0) begin
            r.write = 1'b0; // r0 stays zero.
        end
        return r;
    endfunction

endpackage

`default_nettype wire

// ==== opBundle.sv ====
`timescale 1ns/10ps
`default_nettype none

// one issued slot, pipeline register to lane.
interface opBundle;
    logic                          valid;
    logic [dualExecPkg::DATA_W-1:0] pc;
    dualExecPkg::instWord_u        inst;
    logic [dualExecPkg::DATA_W-1:0] rsValue;
    logic [dualExecPkg::DATA_W-1:0] rtValue;

    modport pipeReg (
        output valid,
        output pc,
        output inst,
        output rsValue,
        output rtValue
    );

    modport lane (
        input valid,
        input pc,
        input inst,
        input rsValue,
        input rtValue
    );
endinterface

`default_nettype wire

// ==== laneResult.sv ====
`timescale 1ns/10ps
`default_nettype none

// one lane's result, lane to merge.
interface laneResult;
    logic                          valid;
    logic                          wen;
    logic [dualExecPkg::REG_W-1:0]  waddr;
    logic [dualExecPkg::DATA_W-1:0] wdata;
    logic                          overflow;
    logic [dualExecPkg::DATA_W-1:0] pc; // for the exception report.

    modport lane (
        output valid,
        output wen,
        output waddr,
        output wdata,
        output overflow,
        output pc
    );

    modport merge (
        input valid,
        input wen,
        input waddr,
        input wdata,
        input overflow,
        input pc
    );
endinterface

`default_nettype wire

// ==== idExReg.sv ====
`timescale 1ns/10ps
`default_nettype none

module idExReg (
    input wire logic                           clk,
    input wire logic                           rst,
    input wire logic                           clear1,
    input wire logic                           clear2,
    input wire logic                           ena1,
    input wire logic                           ena2,

    input wire logic                           masterValid,
    input wire logic [dualExecPkg::DATA_W-1:0] masterPc,
    input wire dualExecPkg::instWord_u         masterInst,
    input wire logic [dualExecPkg::DATA_W-1:0] masterRsValue,
    input wire logic [dualExecPkg::DATA_W-1:0] masterRtValue,

    input wire logic                           slaveValid,
    input wire logic [dualExecPkg::DATA_W-1:0] slavePc,
    input wire dualExecPkg::instWord_u         slaveInst,
    input wire logic [dualExecPkg::DATA_W-1:0] slaveRsValue,
    input wire logic [dualExecPkg::DATA_W-1:0] slaveRtValue,

    opBundle.pipeReg                           masterOp,
    opBundle.pipeReg                           slaveOp
);

    // master slot.
    always_ff @(posedge clk) begin
        if (rst | clear1) begin
            masterOp.valid   <= 1'b0;
            masterOp.pc      <= '0;
            masterOp.inst    <= '0;
            masterOp.rsValue <= '0;
            masterOp.rtValue <= '0;
        end else if (ena1) begin
            masterOp.valid   <= masterValid;
            masterOp.pc      <= masterPc;
            masterOp.inst    <= masterInst;
            masterOp.rsValue <= masterRsValue;
            masterOp.rtValue <= masterRtValue;
        end else begin
            masterOp.valid <= 1'b0; // stall shows as a bubble.
        end
    end

    // slave slot, same rules with its own controls.
    always_ff @(posedge clk) begin
        if (rst | clear2) begin
            slaveOp.valid   <= 1'b0;
            slaveOp.pc      <= '0;
            slaveOp.inst    <= '0;
            slaveOp.rsValue <= '0;
            slaveOp.rtValue <= '0;
        end else if (ena2) begin
            slaveOp.valid   <= slaveValid;
            slaveOp.pc      <= slavePc;
            slaveOp.inst    <= slaveInst;
            slaveOp.rsValue <= slaveRsValue;
            slaveOp.rtValue <= slaveRtValue;
        end else begin
            slaveOp.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== masterLane.sv ====
`timescale 1ns/10ps
`default_nettype none

module masterLane (
    opBundle.lane                                op,
    laneResult.lane                              res,
    output logic                                 branchTaken,
    output logic [dualExecPkg::DATA_W-1:0]       branchTarget
);

    logic [dualExecPkg::DATA_W-1:0] opB;
    logic [dualExecPkg::DATA_W-1:0] branchOffset;
    dualExecPkg::aluResult_t        alu;
    logic                           isBeq;
    logic                           isBne;
    logic                           operandsEqual;

    always_comb begin
        opB = dualExecPkg::operandB(op.inst, op.rtValue);
        alu = dualExecPkg::aluCompute(op.inst, op.rsValue, opB);
    end

    assign res.valid    = op.valid;
    assign res.wen      = alu.write;
    assign res.waddr    = alu.dest;
    assign res.wdata    = alu.value;
    assign res.overflow = alu.overflow;
    assign res.pc       = op.pc;

    // branch resolution.
    assign isBeq         = (op.inst.iType.op == dualExecPkg::OP_BEQ);
    assign isBne         = (op.inst.iType.op == dualExecPkg::OP_BNE);
    assign operandsEqual = (op.rsValue == op.rtValue);
    assign branchTaken   = (isBeq & operandsEqual) | (isBne & ~operandsEqual);

    // word offset, sign extended.
    assign branchOffset = {{14{op.inst.iType.imm16[15]}}, op.inst.iType.imm16, 2'b00};
    assign branchTarget = op.pc + 32'd4 + branchOffset;

endmodule

`default_nettype wire

// ==== slaveLane.sv ====
`timescale 1ns/10ps
`default_nettype none

module slaveLane (
    opBundle.lane   op,
    laneResult.lane res
);

    logic [dualExecPkg::DATA_W-1:0] opB;
    dualExecPkg::aluResult_t        alu;

    // branch opcodes decode to no write here.
    always_comb begin
        opB = dualExecPkg::operandB(op.inst, op.rtValue);
        alu = dualExecPkg::aluCompute(op.inst, op.rsValue, opB);
    end

    assign res.valid    = op.valid;
    assign res.wen      = alu.write;
    assign res.waddr    = alu.dest;
    assign res.wdata    = alu.value;
    assign res.overflow = alu.overflow;
    assign res.pc       = op.pc; // delay slot pc for exceptions.

endmodule

`default_nettype wire

// ==== resultMerge.sv ====
`timescale 1ns/10ps
`default_nettype none

module resultMerge (
    input wire logic                           clk,
    input wire logic                           rst,
    laneResult.merge                           masterRes,
    laneResult.merge                           slaveRes,
    input wire logic                           branchTakenIn,
    input wire logic [dualExecPkg::DATA_W-1:0] branchTargetIn,
    output logic                               wb0Wen,
    output logic                               wb1Wen,
    output logic [dualExecPkg::REG_W-1:0]      wb0Addr,
    output logic [dualExecPkg::REG_W-1:0]      wb1Addr,
    output logic [dualExecPkg::DATA_W-1:0]     wb0Data,
    output logic [dualExecPkg::DATA_W-1:0]     wb1Data,
    output logic                               branchTaken,
    output logic [dualExecPkg::DATA_W-1:0]     branchTarget,
    output logic                               exceptValid,
    output logic [dualExecPkg::DATA_W-1:0]     exceptPc
);

    logic masterOvf;
    logic slaveOvf;
    logic masterWrite;
    logic slaveWrite;
    logic sameDest;

    always_comb begin
        masterOvf   = masterRes.valid & masterRes.overflow;
        slaveOvf    = slaveRes.valid & slaveRes.overflow;
        // master overflow kills the delay slot write too.
        slaveWrite  = slaveRes.valid & slaveRes.wen & ~slaveRes.overflow & ~masterOvf;
        sameDest    = slaveWrite & (masterRes.waddr == slaveRes.waddr);
        // slave is younger, so it wins a shared destination.
        masterWrite = masterRes.valid & masterRes.wen & ~masterRes.overflow & ~sameDest;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb0Wen      <= 1'b0;
            wb1Wen      <= 1'b0;
            branchTaken <= 1'b0;
            exceptValid <= 1'b0;
        end else begin
            wb0Wen      <= masterWrite;
            wb1Wen      <= slaveWrite;
            branchTaken <= masterRes.valid & branchTakenIn;
            exceptValid <= masterOvf | slaveOvf;
        end
    end

    always_ff @(posedge clk) begin
        wb0Addr      <= masterRes.waddr;
        wb0Data      <= masterRes.wdata;
        wb1Addr      <= slaveRes.waddr;
        wb1Data      <= slaveRes.wdata;
        branchTarget <= branchTargetIn;
        exceptPc     <= masterOvf ? masterRes.pc : slaveRes.pc; // older slot first.
    end

endmodule

`default_nettype wire

// ==== dualExecTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module dualExecTop (
    input wire logic                           clk,
    input wire logic                           rst,
    input wire logic                           clear1,
    input wire logic                           clear2,
    input wire logic                           ena1,
    input wire logic                           ena2,

    input wire logic                           masterValid,
    input wire logic [dualExecPkg::DATA_W-1:0] masterPc,
    input wire dualExecPkg::instWord_u         masterInst,
    input wire logic [dualExecPkg::DATA_W-1:0] masterRsValue,
    input wire logic [dualExecPkg::DATA_W-1:0] masterRtValue,

    input wire logic                           slaveValid,
    input wire logic [dualExecPkg::DATA_W-1:0] slavePc,
    input wire dualExecPkg::instWord_u         slaveInst,
    input wire logic [dualExecPkg::DATA_W-1:0] slaveRsValue,
    input wire logic [dualExecPkg::DATA_W-1:0] slaveRtValue,

    output logic                               wb0Wen,
    output logic                               wb1Wen,
    output logic [dualExecPkg::REG_W-1:0]      wb0Addr,
    output logic [dualExecPkg::REG_W-1:0]      wb1Addr,
    output logic [dualExecPkg::DATA_W-1:0]     wb0Data,
    output logic [dualExecPkg::DATA_W-1:0]     wb1Data,
    output logic                               branchTaken,
    output logic [dualExecPkg::DATA_W-1:0]     branchTarget,
    output logic                               exceptValid,
    output logic [dualExecPkg::DATA_W-1:0]     exceptPc
);

    opBundle   masterOp ();
    opBundle   slaveOp ();
    laneResult masterRes ();
    laneResult slaveRes ();

    logic                           laneBranchTaken;
    logic [dualExecPkg::DATA_W-1:0] laneBranchTarget;

    idExReg uIdExReg (
        .clk           (clk),
        .rst           (rst),
        .clear1        (clear1),
        .clear2        (clear2),
        .ena1          (ena1),
        .ena2          (ena2),
        .masterValid   (masterValid),
        .masterPc      (masterPc),
        .masterInst    (masterInst),
        .masterRsValue (masterRsValue),
        .masterRtValue (masterRtValue),
        .slaveValid    (slaveValid),
        .slavePc       (slavePc),
        .slaveInst     (slaveInst),
        .slaveRsValue  (slaveRsValue),
        .slaveRtValue  (slaveRtValue),
        .masterOp      (masterOp),
        .slaveOp       (slaveOp)
    );

    masterLane uMasterLane (
        .op           (masterOp),
        .res          (masterRes),
        .branchTaken  (laneBranchTaken),
        .branchTarget (laneBranchTarget)
    );

    slaveLane uSlaveLane (
        .op  (slaveOp),
        .res (slaveRes)
    );

    resultMerge uResultMerge (
        .clk            (clk),
        .rst            (rst),
        .masterRes      (masterRes),
        .slaveRes       (slaveRes),
        .branchTakenIn  (laneBranchTaken),
        .branchTargetIn (laneBranchTarget),
        .wb0Wen         (wb0Wen),
        .wb1Wen         (wb1Wen),
        .wb0Addr        (wb0Addr),
        .wb1Addr        (wb1Addr),
        .wb0Data        (wb0Data),
        .wb1Data        (wb1Data),
        .branchTaken    (branchTaken),
        .branchTarget   (branchTarget),
        .exceptValid    (exceptValid),
        .exceptPc       (exceptPc)
    );

endmodule

`default_nettype wire

// ==== tbClock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbClock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk; // 8 ns period.

endmodule

`default_nettype wire

// ==== dualExecTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module dualExecTb;

    typedef struct packed {
        logic        wen;
        logic [4:0]  addr;
        logic [31:0] data;
        logic        ovf;
    } laneExp_t;

    typedef struct packed {
        logic        wb0Wen;
        logic [4:0]  wb0Addr;
        logic [31:0] wb0Data;
        logic        wb1Wen;
        logic [4:0]  wb1Addr;
        logic [31:0] wb1Data;
        logic        brTaken;
        logic [31:0] brTarget;
        logic        excValid;
        logic [31:0] excPc;
    } outExp_t;

    logic clk;
    logic rst, clear1, clear2, ena1, ena2;
    logic masterValid, slaveValid;
    logic [31:0] masterPc, masterRsValue, masterRtValue;
    logic [31:0] slavePc, slaveRsValue, slaveRtValue;
    dualExecPkg::instWord_u masterInst, slaveInst;
    logic wb0Wen, wb1Wen, branchTaken, exceptValid;
    logic [4:0] wb0Addr, wb1Addr;
    logic [31:0] wb0Data, wb1Data, branchTarget, exceptPc;

    integer seed = 32'h9660;
    integer errors = 0;
    integer checks = 0;
    logic [31:0] pcCount = 32'h0000_1000;
    logic ctrlE1 = 1'b1, ctrlE2 = 1'b1, ctrlC1 = 1'b0, ctrlC2 = 1'b0;
    outExp_t expQ[$];
    outExp_t cur;
    logic mergeRst;

    tbClock uClk (.clk(clk));

    dualExecTop uut (
        .clk(clk), .rst(rst), .clear1(clear1), .clear2(clear2), .ena1(ena1), .ena2(ena2),
        .masterValid(masterValid), .masterPc(masterPc), .masterInst(masterInst),
        .masterRsValue(masterRsValue), .masterRtValue(masterRtValue),
        .slaveValid(slaveValid), .slavePc(slavePc), .slaveInst(slaveInst),
        .slaveRsValue(slaveRsValue), .slaveRtValue(slaveRtValue),
        .wb0Wen(wb0Wen), .wb1Wen(wb1Wen), .wb0Addr(wb0Addr), .wb1Addr(wb1Addr),
        .wb0Data(wb0Data), .wb1Data(wb1Data), .branchTaken(branchTaken),
        .branchTarget(branchTarget), .exceptValid(exceptValid), .exceptPc(exceptPc)
    );

    // reference ALU from the instruction set rules.
    function automatic laneExp_t refAlu(logic [31:0] w, logic [31:0] a, logic [31:0] rt);
        laneExp_t r;
        logic [32:0] wide;
        logic [31:0] sx;
        sx = {{16{w[15]}}, w[15:0]};
        r = '0;
        if (w[31:26] == 6'h00) begin
            r.addr = w[15:11];
            r.wen = 1'b1;
            case (w[5:0])
                6'h20: begin
                    wide = {a[31], a} + {rt[31], rt};
                    r.data = wide[31:0];
                    r.ovf = wide[32] ^ wide[31];
                end
                6'h21: r.data = a + rt;
                6'h22: begin
                    wide = {a[31], a} - {rt[31], rt};
                    r.data = wide[31:0];
                    r.ovf = wide[32] ^ wide[31];
                end
                6'h23: r.data = a - rt;
                6'h24: r.data = a & rt;
                6'h25: r.data = a | rt;
                6'h26: r.data = a ^ rt;
                6'h2a: r.data = ($signed(a) < $signed(rt)) ? 32'd1 : 32'd0;
                6'h00: r.data = rt << w[10:6];
                6'h02: r.data = rt >> w[10:6];
                default: r.wen = 1'b0;
            endcase
        end else begin
            r.addr = w[20:16];
            r.wen = 1'b1;
            case (w[31:26])
                6'h08: begin
                    wide = {a[31], a} + {sx[31], sx};
                    r.data = wide[31:0];
                    r.ovf = wide[32] ^ wide[31];
                end
                6'h09: r.data = a + sx;
                6'h0c: r.data = a & {16'h0, w[15:0]};
                6'h0d: r.data = a | {16'h0, w[15:0]};
                6'h0f: r.data = {w[15:0], 16'h0};
                default: r.wen = 1'b0;
            endcase
        end
        if (r.addr == 5'd0) r.wen = 1'b0;
        return r;
    endfunction

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] want);
        $display("Fail %s: got 0x%h expected 0x%h", name, got, want);
        errors = errors + 1;
    endtask

    // prediction for the outputs two edges after these inputs are sampled.
    always @(posedge clk) begin : predict
        laneExp_t m, s;
        outExp_t o;
        logic mv, sv, mOvf, sOvf;
        mergeRst = rst; // reset seen by the merge stage at this edge.
        m = refAlu(masterInst, masterRsValue, masterRtValue);
        s = refAlu(slaveInst, slaveRsValue, slaveRtValue);
        mv = !rst && !clear1 && ena1 && masterValid;
        sv = !rst && !clear2 && ena2 && slaveValid;
        mOvf = mv & m.ovf;
        sOvf = sv & s.ovf;
        o = '0;
        o.wb1Wen = sv & s.wen & !s.ovf & !mOvf;
        o.wb0Wen = mv & m.wen & !m.ovf & !(o.wb1Wen && m.addr == s.addr);
        o.wb0Addr = m.addr;
        o.wb0Data = m.data;
        o.wb1Addr = s.addr;
        o.wb1Data = s.data;
        o.excValid = mOvf | sOvf;
        o.excPc = mOvf ? masterPc : slavePc;
        o.brTaken = mv && ((masterInst[31:26] == 6'h04 && masterRsValue == masterRtValue) ||
                           (masterInst[31:26] == 6'h05 && masterRsValue != masterRtValue));
        o.brTarget = masterPc + 32'd4 + {{14{masterInst[15]}}, masterInst[15:0], 2'b00};
        expQ.push_back(o);
    end

    always @(negedge clk) begin
        if (expQ.size() == 2) begin
            cur = expQ.pop_front();
            checks = checks + 1;
            if (mergeRst) begin
                // reset at the merge edge clears every strobe.
                cur.wb0Wen = 1'b0;
                cur.wb1Wen = 1'b0;
                cur.brTaken = 1'b0;
                cur.excValid = 1'b0;
            end
            assert (wb0Wen === cur.wb0Wen) else mismatch("wb0Wen", wb0Wen, cur.wb0Wen);
            assert (wb1Wen === cur.wb1Wen) else mismatch("wb1Wen", wb1Wen, cur.wb1Wen);
            assert (branchTaken === cur.brTaken)
                else mismatch("branchTaken", branchTaken, cur.brTaken);
            assert (exceptValid === cur.excValid)
                else mismatch("exceptValid", exceptValid, cur.excValid);
            if (cur.wb0Wen) begin
                assert (wb0Addr === cur.wb0Addr) else mismatch("wb0Addr", wb0Addr, cur.wb0Addr);
                assert (wb0Data === cur.wb0Data) else mismatch("wb0Data", wb0Data, cur.wb0Data);
            end
            if (cur.wb1Wen) begin
                assert (wb1Addr === cur.wb1Addr) else mismatch("wb1Addr", wb1Addr, cur.wb1Addr);
                assert (wb1Data === cur.wb1Data) else mismatch("wb1Data", wb1Data, cur.wb1Data);
            end
            if (cur.brTaken) begin
                assert (branchTarget === cur.brTarget)
                    else mismatch("branchTarget", branchTarget, cur.brTarget);
            end
            if (cur.excValid) begin
                assert (exceptPc === cur.excPc) else mismatch("exceptPc", exceptPc, cur.excPc);
            end
        end
    end

    function automatic logic [31:0] mkR(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
                                        logic [4:0] rd, logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] mkI(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                        logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] randAlu();
        logic [31:0] r;
        logic [5:0] fns [10];
        logic [5:0] ops [5];
        integer sel;
        fns = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a, 6'h00, 6'h02};
        ops = '{6'h08, 6'h09, 6'h0c, 6'h0d, 6'h0f};
        r = $random(seed);
        sel = {$random(seed)} % 15;
        if (sel < 10) return mkR(fns[sel], r[4:0], r[9:5], r[14:10], r[19:15]);
        return mkI(ops[sel-10], r[4:0], r[9:5], r[31:16]);
    endfunction

    // one issue cycle for both slots.
    task automatic issue(input logic mv, input logic [31:0] mi, input logic [31:0] mrs,
                         input logic [31:0] mrt, input logic sv, input logic [31:0] si,
                         input logic [31:0] srs, input logic [31:0] srt);
        @(posedge clk);
        masterValid <= mv;
        masterInst <= mi;
        masterRsValue <= mrs;
        masterRtValue <= mrt;
        masterPc <= pcCount;
        slaveValid <= sv;
        slaveInst <= si;
        slaveRsValue <= srs;
        slaveRtValue <= srt;
        slavePc <= pcCount + 32'd4;
        ena1 <= ctrlE1;
        ena2 <= ctrlE2;
        clear1 <= ctrlC1;
        clear2 <= ctrlC2;
        pcCount = pcCount + 32'd8;
    endtask

    task automatic issueRandom();
        issue(1'b1, randAlu(), $random(seed), $random(seed),
              1'b1, randAlu(), $random(seed), $random(seed));
    endtask

    task automatic waitForExcept();
        integer n;
        n = 0;
        while (!exceptValid && n < 8) begin
            @(negedge clk);
            n = n + 1;
        end
        if (!exceptValid) begin
            $display("timeout waiting for an exception report");
            errors = errors + 1;
        end
    endtask

    initial begin : watchdog
        integer n;
        for (n = 0; n < 2000; n = n + 1) @(posedge clk);
        $display("timeout: run did not finish in time");
        $display("tests failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        clear1 = 1'b0;
        clear2 = 1'b0;
        ena1 = 1'b0;
        ena2 = 1'b0;
        masterValid = 1'b0;
        slaveValid = 1'b0;
        masterPc = '0;
        slavePc = '0;
        masterInst = '0;
        slaveInst = '0;
        masterRsValue = '0;
        masterRtValue = '0;
        slaveRsValue = '0;
        slaveRtValue = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        repeat (60) issueRandom(); // random ALU mix, r0 included.

        // branches while the delay slot still writes.
        issue(1'b1, mkI(6'h04, 5'd1, 5'd2, 16'h0010), 32'h55, 32'h55,
              1'b1, mkR(6'h21, 5'd3, 5'd4, 5'd9, 5'd0), 32'h10, 32'h20);
        issue(1'b1, mkI(6'h04, 5'd1, 5'd2, 16'hfff0), 32'h55, 32'h56,
              1'b1, mkR(6'h25, 5'd3, 5'd4, 5'd10, 5'd0), 32'h10, 32'h20);
        issue(1'b1, mkI(6'h05, 5'd1, 5'd2, 16'h8000), 32'h7, 32'h7,
              1'b1, mkI(6'h09, 5'd3, 5'd11, 16'hffff), 32'h10, 32'h0);
        issue(1'b1, mkI(6'h05, 5'd1, 5'd2, 16'hfffc), 32'h7, 32'h8,
              1'b1, mkI(6'h0f, 5'd3, 5'd12, 16'hbeef), 32'h0, 32'h0);

        // master overflow squashes both writes.
        issue(1'b1, mkR(6'h20, 5'd1, 5'd2, 5'd5, 5'd0), 32'h7fff_ffff, 32'h1,
              1'b1, mkR(6'h21, 5'd3, 5'd4, 5'd6, 5'd0), 32'h1, 32'h2);
        issue(1'b0, '0, '0, '0, 1'b0, '0, '0, '0);
        waitForExcept();
        // slave overflow alone.
        issue(1'b1, mkR(6'h21, 5'd1, 5'd2, 5'd5, 5'd0), 32'h3, 32'h4,
              1'b1, mkR(6'h22, 5'd3, 5'd4, 5'd6, 5'd0), 32'h8000_0000, 32'h1);
        issue(1'b0, '0, '0, '0, 1'b0, '0, '0, '0);
        waitForExcept();
        issue(1'b1, mkI(6'h08, 5'd1, 5'd7, 16'h8000), 32'h8000_0000, 32'h0,
              1'b1, mkI(6'h08, 5'd1, 5'd8, 16'h0001), 32'h5, 32'h0);

        // same destination so the slave wins.
        issue(1'b1, mkR(6'h21, 5'd1, 5'd2, 5'd13, 5'd0), 32'h1, 32'h2,
              1'b1, mkR(6'h26, 5'd3, 5'd4, 5'd13, 5'd0), 32'hf0, 32'h0f);
        issue(1'b1, mkI(6'h0d, 5'd1, 5'd14, 16'h00ff), 32'h100, 32'h0,
              1'b1, mkR(6'h2a, 5'd3, 5'd4, 5'd14, 5'd0), 32'hffff_ffff, 32'h1);

        // reset while results wait in the merge stage.
        issue(1'b1, mkR(6'h21, 5'd1, 5'd2, 5'd15, 5'd0), 32'h1, 32'h2,
              1'b1, mkR(6'h22, 5'd3, 5'd4, 5'd16, 5'd0), 32'h8000_0000, 32'h1);
        issue(1'b0, '0, '0, '0, 1'b0, '0, '0, '0);
        rst <= 1'b1;
        issue(1'b1, mkI(6'h04, 5'd1, 5'd2, 16'h0020), 32'h9, 32'h9,
              1'b1, mkR(6'h21, 5'd3, 5'd4, 5'd17, 5'd0), 32'h3, 32'h4);
        rst <= 1'b0;
        issue(1'b0, '0, '0, '0, 1'b0, '0, '0, '0);
        rst <= 1'b1;
        issue(1'b0, '0, '0, '0, 1'b0, '0, '0, '0);
        rst <= 1'b0;

        // stalls and clears per slot.
        ctrlE1 = 1'b0;
        repeat (3) issueRandom();
        ctrlE1 = 1'b1;
        ctrlE2 = 1'b0;
        repeat (3) issueRandom();
        ctrlE2 = 1'b1;
        ctrlC1 = 1'b1;
        repeat (2) issueRandom();
        ctrlC1 = 1'b0;
        ctrlC2 = 1'b1;
        repeat (2) issueRandom();
        ctrlC2 = 1'b0;
        repeat (20) begin
            ctrlE1 = $random(seed);
            ctrlE2 = $random(seed);
            ctrlC1 = ($random(seed) & 3) == 0;
            ctrlC2 = ($random(seed) & 3) == 0;
            issueRandom();
        end
        ctrlE1 = 1'b1;
        ctrlE2 = 1'b1;
        ctrlC1 = 1'b0;
        ctrlC2 = 1'b0;
        repeat (4) issue(1'b0, '0, '0, '0, 1'b0, '0, '0, '0);
        @(posedge clk);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
dualExecPkg.sv
opBundle.sv
laneResult.sv
idExReg.sv
masterLane.sv
slaveLane.sv
resultMerge.sv
dualExecTop.sv
tbClock.sv
dualExecTb.sv
